/* common/dma_pkg.sv */
// shared widths and register map; only the low address byte selects a register, lengths in bytes
package dma_pkg;

  // word and address widths of control and memory ports
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;

  typedef logic [DataWidth-1:0] dma_word_t;
  typedef logic [AddrWidth-1:0] dma_addr_t;

  // register word offsets within a control port
  typedef enum logic [7:0] {
    REG_SRC    = 8'h00,
    REG_DST    = 8'h04,
    // a write here launches the transfer
    REG_LEN    = 8'h08,
    REG_STATUS = 8'h0C
  } dma_reg_e;

  // status word layout
  localparam int unsigned StatusBusyBit    = 0;
  localparam int unsigned StatusCountLsb   = 8;
  localparam int unsigned StatusCountWidth = 8;

endpackage

/* frontend/dma_ctrl_regs.sv */
// round-robin control ports; REG_LEN writes stall while the job queue is full, counts wrap at 255
`timescale 1ns/1ps

module dma_ctrl_regs #(
  parameter int unsigned NumCtrl       = 4,
  parameter int unsigned JobQueueDepth = 2,
  localparam int unsigned PortW = (NumCtrl > 1) ? $clog2(NumCtrl) : 1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic               [NumCtrl-1:0]        ctrl_req_i,
  input  logic               [NumCtrl-1:0]        ctrl_wen_i,
  input  dma_pkg::dma_addr_t [NumCtrl-1:0]        ctrl_add_i,
  input  dma_pkg::dma_word_t [NumCtrl-1:0]        ctrl_wdata_i,
  output logic               [NumCtrl-1:0]        ctrl_gnt_o,
  output logic               [NumCtrl-1:0]        ctrl_r_valid_o,
  output dma_pkg::dma_word_t [NumCtrl-1:0]        ctrl_r_rdata_o,
  output logic                                    job_valid_o,
  output dma_pkg::dma_addr_t                      job_src_o,
  output dma_pkg::dma_addr_t                      job_dst_o,
  output dma_pkg::dma_word_t                      job_len_o,
  output logic               [PortW-1:0]          job_port_o,
  input  logic                                    job_pop_i,
  input  logic                                    done_i,
  input  logic               [PortW-1:0]          done_port_i,
  input  logic                                    engine_idle_i,
  output logic               [NumCtrl-1:0]        term_event_o,
  output logic                                    busy_o
);

  localparam int unsigned QPtrW = (JobQueueDepth > 1) ? $clog2(JobQueueDepth) : 1;
  localparam int unsigned QCntW = $clog2(JobQueueDepth + 1);

  // arbitration
  logic [NumCtrl-1:0] eligible;
  logic [PortW-1:0]   rr_ptr_q;
  logic               gnt_any;
  logic [PortW-1:0]   gnt_idx;
  logic               gnt_wen;
  dma_pkg::dma_reg_e  gnt_off;
  dma_pkg::dma_word_t gnt_rdata;

  // staging, response and completion state
  dma_pkg::dma_addr_t [NumCtrl-1:0]       src_q;
  dma_pkg::dma_addr_t [NumCtrl-1:0]       dst_q;
  logic [NumCtrl-1:0]                     rvalid_q;
  dma_pkg::dma_word_t                     rdata_q;
  logic [NumCtrl-1:0][dma_pkg::StatusCountWidth-1:0] count_q;
  logic [NumCtrl-1:0]                     term_q;
  logic                                   busy_q;

  // job queue
  dma_pkg::dma_addr_t q_src [JobQueueDepth];
  dma_pkg::dma_addr_t q_dst [JobQueueDepth];
  dma_pkg::dma_word_t q_len [JobQueueDepth];
  logic [PortW-1:0]   q_port [JobQueueDepth];
  logic [QPtrW-1:0]   wr_ptr_q;
  logic [QPtrW-1:0]   rd_ptr_q;
  logic [QCntW-1:0]   q_count_q;
  logic               q_full;
  logic               push;

  assign q_full = (q_count_q == QCntW'(JobQueueDepth));

  // a launch needs queue room, everything else goes through
  always_comb begin
    for (int unsigned i = 0; i < NumCtrl; i++) begin
      eligible[i] = ctrl_req_i[i] &&
                    !(!ctrl_wen_i[i] && ctrl_add_i[i][7:0] == dma_pkg::REG_LEN && q_full);
    end
  end

  // first eligible port starting at the round-robin pointer
  always_comb begin
    int unsigned idx;
    gnt_any    = 1'b0;
    gnt_idx    = '0;
    ctrl_gnt_o = '0;
    for (int unsigned k = 0; k < NumCtrl; k++) begin
      idx = (int'(rr_ptr_q) + k) % NumCtrl;
      if (!gnt_any && eligible[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = PortW'(idx);
      end
    end
    if (gnt_any) begin
      ctrl_gnt_o[gnt_idx] = 1'b1;
    end
  end

  assign gnt_wen = ctrl_wen_i[gnt_idx];
  assign gnt_off = dma_pkg::dma_reg_e'(ctrl_add_i[gnt_idx][7:0]);
  assign push    = gnt_any && !gnt_wen && gnt_off == dma_pkg::REG_LEN;

  // read mux, writes return zero
  always_comb begin
    gnt_rdata = '0;
    if (gnt_wen) begin
      case (gnt_off)
        dma_pkg::REG_SRC: gnt_rdata = src_q[gnt_idx];
        dma_pkg::REG_DST: gnt_rdata = dst_q[gnt_idx];
        dma_pkg::REG_STATUS: begin
          gnt_rdata[dma_pkg::StatusBusyBit] = busy_q;
          gnt_rdata[dma_pkg::StatusCountLsb +: dma_pkg::StatusCountWidth] = count_q[gnt_idx];
        end
        default: gnt_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q  <= '0;
      rvalid_q  <= '0;
      term_q    <= '0;
      count_q   <= '0;
      busy_q    <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      q_count_q <= '0;
    end else begin
      rvalid_q <= '0;
      term_q   <= '0;
      if (gnt_any) begin
        rvalid_q[gnt_idx] <= 1'b1;
        rr_ptr_q <= (gnt_idx == PortW'(NumCtrl - 1)) ? '0 : gnt_idx + 1'b1;
      end
      // completion turns into an event and a count step
      if (done_i) begin
        term_q[done_port_i]  <= 1'b1;
        count_q[done_port_i] <= count_q[done_port_i] + 1'b1;
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == QPtrW'(JobQueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (job_pop_i) begin
        rd_ptr_q <= (rd_ptr_q == QPtrW'(JobQueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, job_pop_i})
        2'b10:   q_count_q <= q_count_q + 1'b1;
        2'b01:   q_count_q <= q_count_q - 1'b1;
        default: q_count_q <= q_count_q;
      endcase
      busy_q <= push || (q_count_q != '0) || !engine_idle_i;
    end
  end

  // staging registers, queue storage and read data
  always_ff @(posedge clk_i) begin
    if (gnt_any && !gnt_wen && gnt_off == dma_pkg::REG_SRC) begin
      src_q[gnt_idx] <= ctrl_wdata_i[gnt_idx];
    end
    if (gnt_any && !gnt_wen && gnt_off == dma_pkg::REG_DST) begin
      dst_q[gnt_idx] <= ctrl_wdata_i[gnt_idx];
    end
    if (push) begin
      q_src[wr_ptr_q]  <= src_q[gnt_idx];
      q_dst[wr_ptr_q]  <= dst_q[gnt_idx];
      q_len[wr_ptr_q]  <= ctrl_wdata_i[gnt_idx];
      q_port[wr_ptr_q] <= gnt_idx;
    end
    if (gnt_any) begin
      rdata_q <= gnt_rdata;
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NumCtrl; i++) begin
      ctrl_r_rdata_o[i] = rvalid_q[i] ? rdata_q : '0;
    end
  end

  assign ctrl_r_valid_o = rvalid_q;
  assign job_valid_o    = (q_count_q != '0);
  assign job_src_o      = q_src[rd_ptr_q];
  assign job_dst_o      = q_dst[rd_ptr_q];
  assign job_len_o      = q_len[rd_ptr_q];
  assign job_port_o     = q_port[rd_ptr_q];
  assign term_event_o   = term_q;
  assign busy_o         = busy_q;

endmodule

/* engine/dma_copy_engine.sv */
// one word in flight at a time; lengths are byte counts and any remainder under a word ends the job
`timescale 1ns/1ps

module dma_copy_engine #(
  parameter int unsigned NumCtrl = 4,
  localparam int unsigned PortW = (NumCtrl > 1) ? $clog2(NumCtrl) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       job_valid_i,
  input  dma_pkg::dma_addr_t         job_src_i,
  input  dma_pkg::dma_addr_t         job_dst_i,
  input  dma_pkg::dma_word_t         job_len_i,
  input  logic [PortW-1:0]           job_port_i,
  output logic                       job_pop_o,
  output logic                       done_o,
  output logic [PortW-1:0]           done_port_o,
  output logic                       idle_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output dma_pkg::dma_addr_t         mem_addr_o,
  output dma_pkg::dma_word_t         mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  dma_pkg::dma_word_t         mem_rdata_i
);

  localparam dma_pkg::dma_addr_t AddrStep = dma_pkg::DataWidth / 8;
  localparam dma_pkg::dma_word_t LenStep  = dma_pkg::DataWidth / 8;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_REQ,
    ST_READ_WAIT,
    ST_WRITE_REQ,
    ST_DONE
  } state_e;

  state_e             state_q, state_d;
  dma_pkg::dma_addr_t src_q;
  dma_pkg::dma_addr_t dst_q;
  dma_pkg::dma_word_t rem_q;
  dma_pkg::dma_word_t data_q;
  logic [PortW-1:0]   port_q;
  logic               last_word;

  assign last_word = (rem_q <= LenStep);

  always_comb begin
    state_d    = state_q;
    job_pop_o  = 1'b0;
    done_o     = 1'b0;
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    mem_addr_o = src_q;
    case (state_q)
      ST_IDLE: begin
        if (job_valid_i) begin
          job_pop_o = 1'b1;
          // empty jobs still report completion
          state_d   = (job_len_i == '0) ? ST_DONE : ST_READ_REQ;
        end
      end
      ST_READ_REQ: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = ST_WRITE_REQ;
        end
      end
      ST_WRITE_REQ: begin
        mem_req_o  = 1'b1;
        mem_we_o   = 1'b1;
        mem_addr_o = dst_q;
        if (mem_gnt_i) begin
          done_o  = last_word;
          state_d = last_word ? ST_IDLE : ST_READ_REQ;
        end
      end
      ST_DONE: begin
        done_o  = 1'b1;
        state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // job fields, captured word and address stepping
  always_ff @(posedge clk_i) begin
    if (job_pop_o) begin
      src_q  <= job_src_i;
      dst_q  <= job_dst_i;
      rem_q  <= job_len_i;
      port_q <= job_port_i;
    end
    if (state_q == ST_READ_WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
    if (state_q == ST_WRITE_REQ && mem_gnt_i) begin
      src_q <= src_q + AddrStep;
      dst_q <= dst_q + AddrStep;
      rem_q <= rem_q - LenStep;
    end
  end

  assign mem_wdata_o = data_q;
  assign done_port_o = port_q;
  assign idle_o      = (state_q == ST_IDLE);

endmodule

/* source/dma_addr_router.sv */
// window is [TcdmBase, TcdmBase+TcdmSize); TCDM side sees offsets, external side full addresses
`timescale 1ns/1ps

module dma_addr_router #(
  parameter dma_pkg::dma_addr_t TcdmBase = 32'h1000_0000,
  parameter dma_pkg::dma_addr_t TcdmSize = 32'h0001_0000
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               mem_req_i,
  input  logic                               mem_we_i,
  input  dma_pkg::dma_addr_t                 mem_addr_i,
  input  dma_pkg::dma_word_t                 mem_wdata_i,
  output logic                               mem_gnt_o,
  output logic                               mem_rvalid_o,
  output dma_pkg::dma_word_t                 mem_rdata_o,
  output logic                               tcdm_req_o,
  output logic                               tcdm_we_o,
  output dma_pkg::dma_addr_t                 tcdm_addr_o,
  output dma_pkg::dma_word_t                 tcdm_wdata_o,
  output logic [dma_pkg::DataWidth/8-1:0]    tcdm_be_o,
  input  logic                               tcdm_gnt_i,
  input  logic                               tcdm_rvalid_i,
  input  dma_pkg::dma_word_t                 tcdm_rdata_i,
  output logic                               ext_req_o,
  output logic                               ext_we_o,
  output dma_pkg::dma_addr_t                 ext_addr_o,
  output dma_pkg::dma_word_t                 ext_wdata_o,
  output logic [dma_pkg::DataWidth/8-1:0]    ext_be_o,
  input  logic                               ext_gnt_i,
  input  logic                               ext_rvalid_i,
  input  dma_pkg::dma_word_t                 ext_rdata_i
);

  // one extra bit so the window end cannot wrap
  localparam logic [dma_pkg::AddrWidth:0] TcdmEnd = {1'b0, TcdmBase} + {1'b0, TcdmSize};

  logic sel_tcdm;
  logic rd_tcdm_q;

  assign sel_tcdm = (mem_addr_i >= TcdmBase) && ({1'b0, mem_addr_i} < TcdmEnd);

  assign tcdm_req_o   = mem_req_i && sel_tcdm;
  assign tcdm_we_o    = mem_we_i;
  assign tcdm_addr_o  = mem_addr_i - TcdmBase;
  assign tcdm_wdata_o = mem_wdata_i;
  assign tcdm_be_o    = '1;

  assign ext_req_o    = mem_req_i && !sel_tcdm;
  assign ext_we_o     = mem_we_i;
  assign ext_addr_o   = mem_addr_i;
  assign ext_wdata_o  = mem_wdata_i;
  assign ext_be_o     = '1;

  assign mem_gnt_o = sel_tcdm ? tcdm_gnt_i : ext_gnt_i;

  // remember where the outstanding read went
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_tcdm_q <= 1'b0;
    end else if (mem_req_i && !mem_we_i && mem_gnt_o) begin
      rd_tcdm_q <= sel_tcdm;
    end
  end

  assign mem_rvalid_o = rd_tcdm_q ? tcdm_rvalid_i : ext_rvalid_i;
  assign mem_rdata_o  = rd_tcdm_q ? tcdm_rdata_i : ext_rdata_i;

endmodule

/* source/dmac_wrap.sv */
// single-word req/gnt DMA; one job copies while up to JobQueueDepth wait, jobs finish in launch order
`timescale 1ns/1ps

module dmac_wrap #(
  parameter int unsigned        NumCtrl       = 4,
  parameter int unsigned        JobQueueDepth = 2,
  parameter dma_pkg::dma_addr_t TcdmBase      = 32'h1000_0000,
  parameter dma_pkg::dma_addr_t TcdmSize      = 32'h0001_0000
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic               [NumCtrl-1:0]   ctrl_req_i,
  input  logic               [NumCtrl-1:0]   ctrl_wen_i,
  input  dma_pkg::dma_addr_t [NumCtrl-1:0]   ctrl_add_i,
  input  dma_pkg::dma_word_t [NumCtrl-1:0]   ctrl_wdata_i,
  output logic               [NumCtrl-1:0]   ctrl_gnt_o,
  output logic               [NumCtrl-1:0]   ctrl_r_valid_o,
  output dma_pkg::dma_word_t [NumCtrl-1:0]   ctrl_r_rdata_o,
  output logic               [NumCtrl-1:0]   term_event_o,
  output logic                               busy_o,
  output logic                               tcdm_req_o,
  output logic                               tcdm_we_o,
  output dma_pkg::dma_addr_t                 tcdm_addr_o,
  output dma_pkg::dma_word_t                 tcdm_wdata_o,
  output logic [dma_pkg::DataWidth/8-1:0]    tcdm_be_o,
  input  logic                               tcdm_gnt_i,
  input  logic                               tcdm_rvalid_i,
  input  dma_pkg::dma_word_t                 tcdm_rdata_i,
  output logic                               ext_req_o,
  output logic                               ext_we_o,
  output dma_pkg::dma_addr_t                 ext_addr_o,
  output dma_pkg::dma_word_t                 ext_wdata_o,
  output logic [dma_pkg::DataWidth/8-1:0]    ext_be_o,
  input  logic                               ext_gnt_i,
  input  logic                               ext_rvalid_i,
  input  dma_pkg::dma_word_t                 ext_rdata_i
);

  localparam int unsigned PortW = (NumCtrl > 1) ? $clog2(NumCtrl) : 1;

  // queue head towards the engine
  logic               job_valid, job_pop;
  dma_pkg::dma_addr_t job_src, job_dst;
  dma_pkg::dma_word_t job_len;
  logic [PortW-1:0]   job_port, done_port;
  logic               done, engine_idle;

  // engine memory port
  logic               mem_req, mem_we, mem_gnt, mem_rvalid;
  dma_pkg::dma_addr_t mem_addr;
  dma_pkg::dma_word_t mem_wdata, mem_rdata;

  dma_ctrl_regs #(
    .NumCtrl       ( NumCtrl       ),
    .JobQueueDepth ( JobQueueDepth )
  ) i_dma_ctrl_regs (
    .clk_i, .rst_i,
    .ctrl_req_i, .ctrl_wen_i, .ctrl_add_i, .ctrl_wdata_i,
    .ctrl_gnt_o, .ctrl_r_valid_o, .ctrl_r_rdata_o,
    .job_valid_o   ( job_valid   ),
    .job_src_o     ( job_src     ),
    .job_dst_o     ( job_dst     ),
    .job_len_o     ( job_len     ),
    .job_port_o    ( job_port    ),
    .job_pop_i     ( job_pop     ),
    .done_i        ( done        ),
    .done_port_i   ( done_port   ),
    .engine_idle_i ( engine_idle ),
    .term_event_o, .busy_o
  );

  dma_copy_engine #(
    .NumCtrl ( NumCtrl )
  ) i_dma_copy_engine (
    .clk_i, .rst_i,
    .job_valid_i  ( job_valid   ),
    .job_src_i    ( job_src     ),
    .job_dst_i    ( job_dst     ),
    .job_len_i    ( job_len     ),
    .job_port_i   ( job_port    ),
    .job_pop_o    ( job_pop     ),
    .done_o       ( done        ),
    .done_port_o  ( done_port   ),
    .idle_o       ( engine_idle ),
    .mem_req_o    ( mem_req     ),
    .mem_we_o     ( mem_we      ),
    .mem_addr_o   ( mem_addr    ),
    .mem_wdata_o  ( mem_wdata   ),
    .mem_gnt_i    ( mem_gnt     ),
    .mem_rvalid_i ( mem_rvalid  ),
    .mem_rdata_i  ( mem_rdata   )
  );

  dma_addr_router #(
    .TcdmBase ( TcdmBase ),
    .TcdmSize ( TcdmSize )
  ) i_dma_addr_router (
    .clk_i, .rst_i,
    .mem_req_i    ( mem_req    ),
    .mem_we_i     ( mem_we     ),
    .mem_addr_i   ( mem_addr   ),
    .mem_wdata_i  ( mem_wdata  ),
    .mem_gnt_o    ( mem_gnt    ),
    .mem_rvalid_o ( mem_rvalid ),
    .mem_rdata_o  ( mem_rdata  ),
    .tcdm_req_o, .tcdm_we_o, .tcdm_addr_o, .tcdm_wdata_o, .tcdm_be_o,
    .tcdm_gnt_i, .tcdm_rvalid_i, .tcdm_rdata_i,
    .ext_req_o, .ext_we_o, .ext_addr_o, .ext_wdata_o, .ext_be_o,
    .ext_gnt_i, .ext_rvalid_i, .ext_rdata_i
  );

endmodule

/* bench/tb_mem_model.sv */
// word memory on a req/gnt port, registered gnt after 0-3 idle cycles, rvalid 1-4 cycles after gnt
`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] Salt = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [logic [31:0]];
  int unsigned wait_q;
  int unsigned lat_q;
  logic [31:0] rd_q;
  logic [31:0] be_mask;

  // untouched words hold a pattern of the full address
  function automatic logic [31:0] peek(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return (addr * 32'h9e37_79b1) ^ Salt;
  endfunction

  task automatic poke(input logic [31:0] addr, input logic [31:0] data);
    mem[addr] = data;
  endtask

  // byte enables widened to a bit mask
  assign be_mask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

  always @(posedge clk_i) begin
    if (rst_i) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      wait_q   <= 0;
      lat_q    <= 0;
    end else begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      if (req_i && gnt_o) begin
        if (we_i) begin
          mem[addr_i] = (peek(addr_i) & ~be_mask) | (wdata_i & be_mask);
        end else begin
          rd_q  <= peek(addr_i);
          lat_q <= 1 + ($urandom % 4);
        end
        wait_q <= $urandom % 4;
      end else if (req_i) begin
        if (wait_q == 0) begin
          gnt_o <= 1'b1;
        end else begin
          wait_q <= wait_q - 1;
        end
      end
      // read latency countdown
      if (lat_q != 0) begin
        if (lat_q == 1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= rd_q;
        end
        lat_q <= lat_q - 1;
      end
    end
  end

endmodule

/* bench/tb_dmac_wrap.sv */
// runs the command records of bench/dmac_wrap_testdata.txt, 6 hex words each, from the project root
`timescale 1ns/1ps

module tb_dmac_wrap;

  localparam int unsigned NumCtrl  = 4;
  localparam int unsigned CmdWords = 6;
  localparam int unsigned CmdMax   = 1200;

  logic clk_i;
  logic rst_i;
  logic [NumCtrl-1:0]               ctrl_req;
  logic [NumCtrl-1:0]               ctrl_wen;
  dma_pkg::dma_addr_t [NumCtrl-1:0] ctrl_add;
  dma_pkg::dma_word_t [NumCtrl-1:0] ctrl_wdata;
  logic [NumCtrl-1:0]               ctrl_gnt_o;
  logic [NumCtrl-1:0]               ctrl_r_valid_o;
  dma_pkg::dma_word_t [NumCtrl-1:0] ctrl_r_rdata_o;
  logic [NumCtrl-1:0]               term_event_o;
  logic                             busy_o;
  logic        tcdm_req_o, tcdm_we_o, tcdm_gnt, tcdm_rvalid;
  logic [31:0] tcdm_addr_o, tcdm_wdata_o, tcdm_rdata;
  logic [3:0]  tcdm_be_o;
  logic        ext_req_o, ext_we_o, ext_gnt, ext_rvalid;
  logic [31:0] ext_addr_o, ext_wdata_o, ext_rdata;
  logic [3:0]  ext_be_o;

  logic [31:0]             cmd [CmdMax];
  logic [NumCtrl-1:0]      ev_q [$];
  int                      launch_q [$];
  int unsigned             req_cnt;
  int unsigned             req_mark;
  int unsigned             limit;
  bit                      limit_ready;
  int unsigned             checks;
  int unsigned             errors;
  int unsigned             test_errors;
  int unsigned             tests;
  int unsigned             failed_tests;

  dmac_wrap #(.NumCtrl(NumCtrl)) dut (
    .clk_i, .rst_i,
    .ctrl_req_i(ctrl_req), .ctrl_wen_i(ctrl_wen), .ctrl_add_i(ctrl_add),
    .ctrl_wdata_i(ctrl_wdata), .ctrl_gnt_o, .ctrl_r_valid_o, .ctrl_r_rdata_o,
    .term_event_o, .busy_o,
    .tcdm_req_o, .tcdm_we_o, .tcdm_addr_o, .tcdm_wdata_o, .tcdm_be_o,
    .tcdm_gnt_i(tcdm_gnt), .tcdm_rvalid_i(tcdm_rvalid), .tcdm_rdata_i(tcdm_rdata),
    .ext_req_o, .ext_we_o, .ext_addr_o, .ext_wdata_o, .ext_be_o,
    .ext_gnt_i(ext_gnt), .ext_rvalid_i(ext_rvalid), .ext_rdata_i(ext_rdata)
  );

  tb_mem_model #(.Salt(32'h0000_7c3d)) tcdm_mem (
    .clk_i, .rst_i, .req_i(tcdm_req_o), .we_i(tcdm_we_o), .addr_i(tcdm_addr_o),
    .wdata_i(tcdm_wdata_o), .be_i(tcdm_be_o), .gnt_o(tcdm_gnt),
    .rvalid_o(tcdm_rvalid), .rdata_o(tcdm_rdata)
  );

  tb_mem_model #(.Salt(32'h5e00_0000)) ext_mem (
    .clk_i, .rst_i, .req_i(ext_req_o), .we_i(ext_we_o), .addr_i(ext_addr_o),
    .wdata_i(ext_wdata_o), .be_i(ext_be_o), .gnt_o(ext_gnt),
    .rvalid_o(ext_rvalid), .rdata_o(ext_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // term events and memory request cycles, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (term_event_o != '0) begin
        ev_q.push_back(term_event_o);
      end
      if (tcdm_req_o || ext_req_o) begin
        req_cnt++;
      end
      // every request covers the whole word
      if (tcdm_req_o) begin
        check_word("tcdm_be_o", dma_pkg::dma_word_t'(tcdm_be_o), 32'h0000_000f);
      end
      if (ext_req_o) begin
        check_word("ext_be_o", dma_pkg::dma_word_t'(ext_be_o), 32'h0000_000f);
      end
    end
  end

  initial begin
    wait (limit_ready);
    repeat (limit) @(posedge clk_i);
    $display("timeout after %0d cycles, the transfers did not finish", limit);
    $display("Verification failed");
    $finish;
  end

  task automatic check_word(input string name, input dma_pkg::dma_word_t got,
                            input dma_pkg::dma_word_t exp);
    checks++;
    if (got !== exp) begin
      test_errors++;
      $display("error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_events(input logic [NumCtrl-1:0] got, input logic [NumCtrl-1:0] exp);
    checks++;
    if (got !== exp) begin
      test_errors++;
      $display("error: term_event_o = %h, expected %h", got, exp);
    end
  endtask

  function automatic dma_pkg::dma_word_t mem_peek(input logic [31:0] side,
                                                  input logic [31:0] addr);
    return (side != 0) ? ext_mem.peek(addr) : tcdm_mem.peek(addr);
  endfunction

  task automatic reg_access(input int port, input logic wen, input dma_pkg::dma_addr_t off,
                            input dma_pkg::dma_word_t wdata, output dma_pkg::dma_word_t rdata);
    @(negedge clk_i);
    ctrl_req[port]   = 1'b1;
    ctrl_wen[port]   = wen;
    ctrl_add[port]   = off;
    ctrl_wdata[port] = wdata;
    #1;
    while (!ctrl_gnt_o[port]) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ctrl_req[port] = 1'b0;
    if (!ctrl_r_valid_o[port]) begin
      test_errors++;
      $display("no response on port %0d in the cycle after its grant", port);
    end
    rdata = ctrl_r_rdata_o[port];
  endtask

  // REG_LEN writes on several ports at once, grants give the launch order
  task automatic launch_together(input logic [NumCtrl-1:0] mask, input dma_pkg::dma_word_t len);
    logic [NumCtrl-1:0] pending;
    logic [NumCtrl-1:0] granted;
    bit                 stalled;
    pending = mask;
    granted = '0;
    stalled = 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < NumCtrl; i++) begin
      if (mask[i]) begin
        ctrl_req[i]   = 1'b1;
        ctrl_wen[i]   = 1'b0;
        ctrl_add[i]   = dma_pkg::dma_addr_t'(dma_pkg::REG_LEN);
        ctrl_wdata[i] = len;
      end
    end
    while (pending != '0 || granted != '0) begin
      #1;
      if (ctrl_gnt_o == '0 && pending != '0) begin
        stalled = 1'b1;
      end
      for (int i = 0; i < NumCtrl; i++) begin
        if (pending[i] && ctrl_gnt_o[i]) begin
          launch_q.push_back(i);
          pending[i] = 1'b0;
          granted[i] = 1'b1;
        end
      end
      @(negedge clk_i);
      for (int i = 0; i < NumCtrl; i++) begin
        if (granted[i]) begin
          ctrl_req[i] = 1'b0;
          granted[i]  = 1'b0;
        end
      end
    end
    if (!stalled) begin
      test_errors++;
      $display("a launch against the full job queue was granted without waiting");
    end
  endtask

  task automatic wait_event(input logic [NumCtrl-1:0] exp);
    logic [NumCtrl-1:0] got;
    while (ev_q.size() == 0) begin
      @(negedge clk_i);
    end
    got = ev_q.pop_front();
    check_events(got, exp);
  endtask

  initial begin
    int unsigned        idx;
    int unsigned        words;
    logic [31:0]        op, c1, c2, c3, c4, c5;
    dma_pkg::dma_word_t rdata;
    void'($urandom(32'h3713_6b70));
    rst_i      = 1'b1;
    ctrl_req   = '0;
    ctrl_wen   = '0;
    ctrl_add   = '0;
    ctrl_wdata = '0;
    req_cnt    = 0;
    req_mark   = 0;
    checks     = 0;
    errors     = 0;
    test_errors  = 0;
    tests        = 0;
    failed_tests = 0;
    for (int i = 0; i < CmdMax; i++) begin
      cmd[i] = '0;
    end
    $readmemh("bench/dmac_wrap_testdata.txt", cmd);
    // watchdog budget from the words that will be moved
    words = 0;
    idx = 0;
    while (idx + CmdWords <= CmdMax && cmd[idx] != 0) begin
      if (cmd[idx] == 2 && cmd[idx+2] == 32'h8) begin
        words += cmd[idx+3] / 4;
      end
      if (cmd[idx] == 6) begin
        words += $countones(cmd[idx+1]) * (cmd[idx+2] / 4);
      end
      idx += CmdWords;
    end
    limit = 200 * words + 2000;
    limit_ready = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    idx = 0;
    while (idx + CmdWords <= CmdMax && cmd[idx] != 0) begin
      op = cmd[idx];
      c1 = cmd[idx+1];
      c2 = cmd[idx+2];
      c3 = cmd[idx+3];
      c4 = cmd[idx+4];
      c5 = cmd[idx+5];
      case (op)
        1: begin
          if (c1 != 0) ext_mem.poke(c2, c3);
          else tcdm_mem.poke(c2, c3);
        end
        2: begin
          reg_access(int'(c1), 1'b0, c2, c3, rdata);
          check_word("ctrl_r_rdata_o", rdata, '0);
        end
        3: begin
          reg_access(int'(c1), 1'b1, c2, '0, rdata);
          check_word("ctrl_r_rdata_o", rdata, c3);
        end
        4: wait_event(NumCtrl'(1) << c1);
        5: begin
          for (int unsigned k = 0; k < c5; k++) begin
            check_word($sformatf("dst word %h", c2 + 4 * k), mem_peek(c1, c2 + 4 * k),
                       mem_peek(c3, c4 + 4 * k));
          end
        end
        6: launch_together(c1[NumCtrl-1:0], c2);
        7: begin
          for (int unsigned k = 0; k < c1; k++) begin
            wait_event(NumCtrl'(1) << launch_q.pop_front());
          end
        end
        8: begin
          @(negedge clk_i);
          check_word("busy_o", {31'h0, busy_o}, c1);
        end
        9: req_mark = req_cnt;
        10: begin
          checks++;
          if (req_cnt != req_mark) begin
            test_errors++;
            $display("memory requests were issued for a zero-length job");
          end
        end
        11: begin
          tests++;
          if (test_errors != 0) begin
            failed_tests++;
          end
          errors += test_errors;
          $display("test %0d finished with %0d errors", c1, test_errors);
          test_errors = 0;
        end
        default: begin
          test_errors++;
          $display("unknown command %h in the test data", op);
        end
      endcase
      idx += CmdWords;
    end
    errors += test_errors;
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* bench/dmac_wrap_testdata.txt */
// op p1 p2 p3 p4 p5: 1 preload side addr data | 2 write port off data | 3 read port off exp
// 4 wait event port | 5 check dside daddr sside saddr words | 6 launch mask len | 7 events n
// 8 busy exp | 9 mark requests | a no new requests | b test done id; side 1 ext, 0 tcdm offset
2 0 0 a0000000 0 0
2 0 4 b0000004 0 0
3 0 0 a0000000 0 0
3 0 4 b0000004 0 0
2 3 0 c0000030 0 0
3 3 0 c0000030 0 0
3 1 10 0 0 0
2 1 10 dead 0 0
3 1 10 0 0 0
b 1 0 0 0 0
1 1 80000000 11223344 0 0
1 1 80000004 55667788 0 0
1 1 80000008 99aabbcc 0 0
1 1 8000000c ddeeff00 0 0
1 1 80000010 0badf00d 0 0
1 1 80000014 12345678 0 0
1 1 80000018 87654321 0 0
1 1 8000001c fedcba98 0 0
2 1 0 80000000 0 0
2 1 4 10000100 0 0
2 1 8 20 0 0
8 1 0 0 0 0
4 1 0 0 0 0
8 0 0 0 0 0
5 0 100 1 80000000 8
3 1 c 100 0 0
b 2 0 0 0 0
2 2 0 10000200 0 0
2 2 4 90000000 0 0
2 2 8 20 0 0
3 2 c 1 0 0
4 2 0 0 0 0
5 1 90000000 0 200 8
3 2 c 100 0 0
b 3 0 0 0 0
2 0 0 80001000 0 0
2 0 4 10001000 0 0
2 1 0 80001100 0 0
2 1 4 10001100 0 0
2 2 0 80001200 0 0
2 2 4 10001200 0 0
2 3 0 80001300 0 0
2 3 4 10001300 0 0
6 f 10 0 0 0
7 4 0 0 0 0
5 0 1000 1 80001000 4
5 0 1100 1 80001100 4
5 0 1200 1 80001200 4
5 0 1300 1 80001300 4
3 0 c 100 0 0
3 3 c 100 0 0
b 4 0 0 0 0
2 0 0 80002000 0 0
2 0 4 10002000 0 0
2 0 8 40 0 0
8 1 0 0 0 0
3 0 c 101 0 0
4 0 0 0 0 0
8 0 0 0 0 0
3 0 c 200 0 0
5 0 2000 1 80002000 10
b 5 0 0 0 0
9 0 0 0 0 0
2 3 8 0 0 0
4 3 0 0 0 0
a 0 0 0 0 0
3 3 c 200 0 0
b 6 0 0 0 0

/* dmac_wrap.f */
common/dma_pkg.sv
frontend/dma_ctrl_regs.sv
engine/dma_copy_engine.sv
source/dma_addr_router.sv
source/dmac_wrap.sv
bench/tb_mem_model.sv
bench/tb_dmac_wrap.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_dmac_wrap \
    -f dmac_wrap.f -Mdir build/obj -o sim_tb; then
  echo "build failed"
  exit 1
fi

./build/obj/sim_tb > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "Verification failed" build/sim.log; then
  exit 1
fi
exit 0
